// File: hdl/dt_pkg.sv
package dt_pkg;

	// data line and value widths
	localparam int LINE_W = 64;
	localparam int FEAT_W = 32;

	// chain size, pu field sized from it
	localparam int NUM_PUS = 8;
	localparam int PU_BITS = $clog2(NUM_PUS);

	// node ram and feature ram are both 512 lines
	localparam int NODE_ADDR_W = 9;
	localparam int FEAT_ADDR_W = 9;

	localparam int MAX_TREES = 4;
	localparam int TREE_ID_W = $clog2(MAX_TREES);

	// complete tuples that may wait for issue
	localparam int MAX_PENDING = 4;

	// ctrl line layout
	typedef struct packed {
		logic [38:0] rsvd_hi;
		logic [8:0]  lines_per_tuple;
		logic [10:0] rsvd_mid;
		logic [4:0]  num_trees_m1;
	} cfg_word_t;

	// tree node layout, value is threshold for inner nodes and result for leaves
	typedef struct packed {
		logic [31:0] value;
		logic [15:0] right_off;
		logic [3:0]  rsvd_hi;
		logic [7:0]  feat_idx;
		logic        right_child;
		logic        left_child;
		logic [1:0]  rsvd_lo;
	} node_word_t;

	// one data line, seen as raw bits, config or node
	typedef union packed {
		logic [LINE_W-1:0] raw;
		cfg_word_t         cfg;
		node_word_t        node;
	} dl_word_u;

endpackage

// File: hdl/dt_ifs.sv
`timescale 1ns/1ps

////////////////////
// memory read port
////////////////////

// rdata and rvalid show up one cycle after ren, no back-pressure
interface mem_rd_if #(
	parameter int ADDR_W = dt_pkg::NODE_ADDR_W,
	parameter int DATA_W = dt_pkg::LINE_W
);
	logic              ren;
	logic [ADDR_W-1:0] addr;
	logic [DATA_W-1:0] rdata;
	logic              rvalid;

	modport requester (output ren, output addr, input rdata, input rvalid);
	modport responder (input ren, input addr, output rdata, output rvalid);
endinterface

////////////////////
// tree instruction
////////////////////

// valid/ready handshake, fields stay put while stalled
interface tree_instr_if;
	import dt_pkg::*;

	logic                   valid;
	logic                   ready;
	logic [NODE_ADDR_W-1:0] tree_offset;
	logic [FEAT_ADDR_W-1:0] tuple_offset;
	logic                   last_tree;
	logic                   empty_tree;

	modport issuer (
		output valid, output tree_offset, output tuple_offset,
		output last_tree, output empty_tree, input ready
	);
	modport walker (
		input valid, input tree_offset, input tuple_offset,
		input last_tree, input empty_tree, output ready
	);
endinterface

// File: hdl/line_ram.sv
`timescale 1ns/1ps

module line_ram #(
	parameter int ADDR_W = 9
) (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      we,
	input  logic [ADDR_W-1:0]         waddr,
	input  logic [dt_pkg::LINE_W-1:0] wdata,
	mem_rd_if.responder               rd
);
	import dt_pkg::*;

	logic [LINE_W-1:0] mem [2**ADDR_W];

	// write port and registered read, no reset on storage
	always_ff @(posedge clk) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
		if (rd.ren) begin
			rd.rdata <= mem[rd.addr];
		end
	end

	// read strobe follows ren by one cycle
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rd.rvalid <= 1'b0;
		end else begin
			rd.rvalid <= rd.ren;
		end
	end

endmodule

// File: hdl/pe_ingress.sv
`timescale 1ns/1ps

module pe_ingress #(
	parameter int PE_ID = 0
) (
	input  logic                           clk,
	input  logic                           rst_n,

	input  logic [dt_pkg::LINE_W-1:0]      data_line_in,
	input  logic                           data_line_in_valid,
	input  logic                           data_line_in_last,
	input  logic                           data_line_in_ctrl,
	input  logic                           data_line_in_prog,
	input  logic [dt_pkg::PU_BITS-1:0]     data_line_in_pu,

	output logic [dt_pkg::LINE_W-1:0]      data_line_out,
	output logic                           data_line_out_valid,
	output logic                           data_line_out_last,
	output logic                           data_line_out_ctrl,
	output logic                           data_line_out_prog,
	output logic [dt_pkg::PU_BITS-1:0]     data_line_out_pu,

	output logic                           node_we,
	output logic [dt_pkg::NODE_ADDR_W-1:0] node_waddr,
	output logic [dt_pkg::TREE_ID_W-1:0]   num_trees_m1,
	output logic [dt_pkg::FEAT_ADDR_W-1:0] lines_per_tuple,
	output logic [dt_pkg::TREE_ID_W:0]     num_trees_loaded,
	output logic [dt_pkg::NODE_ADDR_W-1:0] tree_offsets [dt_pkg::MAX_TREES]
);
	import dt_pkg::*;

	dl_word_u             in_word;
	logic                 own_prog;
	logic [TREE_ID_W-1:0] next_tree;

	assign in_word.raw = data_line_in;
	// prog line addressed to this pe goes straight into node ram
	assign own_prog  = data_line_in_prog && (data_line_in_pu == PU_BITS'(PE_ID));
	assign node_we   = own_prog;
	assign next_tree = num_trees_loaded[TREE_ID_W-1:0] + 1'b1;

	////////////////////
	// forwarding
	////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			data_line_out_valid <= 1'b0;
			data_line_out_last  <= 1'b0;
			data_line_out_ctrl  <= 1'b0;
			data_line_out_prog  <= 1'b0;
		end else begin
			data_line_out_valid <= data_line_in_valid;
			data_line_out_last  <= data_line_in_last;
			data_line_out_ctrl  <= data_line_in_ctrl;
			data_line_out_prog  <= data_line_in_prog;
		end
	end

	// payload copy, no reset
	always_ff @(posedge clk) begin
		data_line_out    <= data_line_in;
		data_line_out_pu <= data_line_in_pu;
	end

	////////////////////
	// config and tree programming
	////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			num_trees_m1     <= '0;
			lines_per_tuple  <= '0;
			node_waddr       <= '0;
			num_trees_loaded <= '0;
			for (int i = 0; i < MAX_TREES; i++) begin
				tree_offsets[i] <= '0;
			end
		end else begin
			// only the low bits of the tree count field matter here
			if (data_line_in_ctrl) begin
				num_trees_m1    <= in_word.cfg.num_trees_m1[TREE_ID_W-1:0];
				lines_per_tuple <= in_word.cfg.lines_per_tuple;
			end
			if (own_prog) begin
				node_waddr <= node_waddr + 1'b1;
				// last line closes a tree, next one starts right after it
				if (data_line_in_last && (num_trees_loaded <= {1'b0, num_trees_m1})) begin
					num_trees_loaded <= num_trees_loaded + 1'b1;
					if (num_trees_loaded < {1'b0, num_trees_m1}) begin
						tree_offsets[next_tree] <= node_waddr + 1'b1;
					end
				end
			end
		end
	end

endmodule

// File: hdl/feature_buffer.sv
`timescale 1ns/1ps

module feature_buffer #(
	parameter int PE_ID = 0
) (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic [dt_pkg::LINE_W-1:0]      data_line_in,
	input  logic                           data_line_in_valid,
	input  logic [dt_pkg::FEAT_ADDR_W-1:0] lines_per_tuple,
	input  logic                           pending_full,
	input  logic                           leaf_out_valid,
	input  logic                           leaf_out_last,
	output logic                           data_line_in_ready,
	mem_rd_if.responder                    rd
);
	import dt_pkg::*;

	localparam int OCC_W = FEAT_ADDR_W + 1;
	// headroom for lines still in flight from upstream pes
	localparam int OCC_LIMIT = 2**FEAT_ADDR_W - PE_ID - 1;

	logic [FEAT_ADDR_W-1:0] wr_ptr;
	logic [OCC_W-1:0]       occupancy;
	logic                   tuple_retired;

	// tuple lines only, prog and ctrl lines never land here
	line_ram #(
		.ADDR_W (FEAT_ADDR_W)
	) u_ram (
		.clk   (clk),
		.rst_n (rst_n),
		.we    (data_line_in_valid),
		.waddr (wr_ptr),
		.wdata (data_line_in),
		.rd    (rd)
	);

	// last tree of a tuple done, its lines can go
	assign tuple_retired = leaf_out_valid && leaf_out_last;

	assign data_line_in_ready = !pending_full && (occupancy < OCC_W'(OCC_LIMIT));

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr    <= '0;
			occupancy <= '0;
		end else begin
			// pointer wraps with the ram depth
			wr_ptr    <= wr_ptr + FEAT_ADDR_W'(data_line_in_valid);
			occupancy <= occupancy + OCC_W'(data_line_in_valid)
				- (tuple_retired ? OCC_W'(lines_per_tuple) : '0);
		end
	end

endmodule

// File: hdl/tuple_issue.sv
`timescale 1ns/1ps

module tuple_issue (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           tuple_done_in,
	input  logic [dt_pkg::TREE_ID_W-1:0]   num_trees_m1,
	input  logic [dt_pkg::TREE_ID_W:0]     num_trees_loaded,
	input  logic [dt_pkg::NODE_ADDR_W-1:0] tree_offsets [dt_pkg::MAX_TREES],
	input  logic [dt_pkg::FEAT_ADDR_W-1:0] lines_per_tuple,
	output logic                           pending_full,
	tree_instr_if.issuer                   issue
);
	import dt_pkg::*;

	localparam int CNT_W = $clog2(MAX_PENDING + 1);

	logic [CNT_W-1:0]       pending_cnt;
	logic [TREE_ID_W-1:0]   tree_id;
	logic [FEAT_ADDR_W-1:0] tuple_off;
	logic                   issue_fire;
	logic                   tuple_fire;

	// instruction fields come straight from registers, stable under stall
	assign issue.valid        = (pending_cnt != '0);
	assign issue.tree_offset  = tree_offsets[tree_id];
	assign issue.tuple_offset = tuple_off;
	assign issue.last_tree    = (tree_id == num_trees_m1);
	// configured but never programmed
	assign issue.empty_tree   = ({1'b0, tree_id} >= num_trees_loaded);

	assign issue_fire   = issue.valid && issue.ready;
	assign tuple_fire   = issue_fire && issue.last_tree;
	assign pending_full = (pending_cnt == CNT_W'(MAX_PENDING));

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pending_cnt <= '0;
			tree_id     <= '0;
			tuple_off   <= '0;
		end else begin
			// tuple completes and retires in the same cycle, count holds
			case ({tuple_done_in, tuple_fire})
				2'b10:   pending_cnt <= pending_cnt + 1'b1;
				2'b01:   pending_cnt <= pending_cnt - 1'b1;
				default: pending_cnt <= pending_cnt;
			endcase
			if (issue_fire) begin
				tree_id <= issue.last_tree ? '0 : tree_id + 1'b1;
			end
			// offset wraps with the feature ram
			if (tuple_fire) begin
				tuple_off <= tuple_off + lines_per_tuple;
			end
		end
	end

endmodule

// File: hdl/tree_walker.sv
`timescale 1ns/1ps

module tree_walker (
	input  logic                      clk,
	input  logic                      rst_n,
	tree_instr_if.walker              instr,
	mem_rd_if.requester               node_rd,
	mem_rd_if.requester               feat_rd,
	output logic [dt_pkg::FEAT_W-1:0] leaf_out,
	output logic                      leaf_out_valid,
	output logic                      leaf_out_last
);
	import dt_pkg::*;

	localparam logic [1:0] S_IDLE = 2'd0;
	localparam logic [1:0] S_NODE = 2'd1;
	localparam logic [1:0] S_FEAT = 2'd2;
	localparam logic [1:0] S_EMIT = 2'd3;

	logic [1:0]             state;
	logic [NODE_ADDR_W-1:0] node_addr;
	logic [FEAT_ADDR_W-1:0] tuple_off;
	dl_word_u               node_in;
	dl_word_u               node_q;
	logic                   is_leaf;
	logic [FEAT_W-1:0]      feature;
	logic                   go_left;
	logic                   take_child;
	logic [NODE_ADDR_W-1:0] next_addr;

	////////////////////
	// node decode and compare
	////////////////////

	// node as it comes out of the ram
	assign node_in.raw = node_rd.rdata;
	assign is_leaf     = !node_in.node.left_child && !node_in.node.right_child;

	// two features per line, odd index takes the upper half
	assign feature = node_q.node.feat_idx[0] ? feat_rd.rdata[2*FEAT_W-1:FEAT_W]
		: feat_rd.rdata[FEAT_W-1:0];
	assign go_left    = (feature < node_q.node.value);
	assign take_child = go_left ? node_q.node.left_child : node_q.node.right_child;
	// left child sits right behind its parent
	assign next_addr  = go_left ? node_addr + 1'b1
		: node_addr + node_q.node.right_off[NODE_ADDR_W-1:0];

	////////////////////
	// memory requests
	////////////////////

	assign instr.ready = (state == S_IDLE);

	// root on a new instruction, child after a compare
	assign node_rd.ren = ((state == S_IDLE) && instr.valid && !instr.empty_tree)
		|| ((state == S_FEAT) && feat_rd.rvalid && take_child);
	assign node_rd.addr = (state == S_IDLE) ? instr.tree_offset : next_addr;

	assign feat_rd.ren  = (state == S_NODE) && node_rd.rvalid && !is_leaf;
	assign feat_rd.addr = tuple_off + FEAT_ADDR_W'(node_in.node.feat_idx[7:1]);

	assign leaf_out_valid = (state == S_EMIT);

	////////////////////
	// fsm
	////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= S_IDLE;
		end else begin
			case (state)
				S_IDLE: begin
					if (instr.valid) begin
						state <= instr.empty_tree ? S_EMIT : S_NODE;
					end
				end
				S_NODE: begin
					if (node_rd.rvalid) begin
						state <= is_leaf ? S_EMIT : S_FEAT;
					end
				end
				S_FEAT: begin
					// missing child ends the walk at this node
					if (feat_rd.rvalid) begin
						state <= take_child ? S_NODE : S_EMIT;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// walk context and result, no reset
	always_ff @(posedge clk) begin
		case (state)
			S_IDLE: begin
				if (instr.valid) begin
					node_addr     <= instr.tree_offset;
					tuple_off     <= instr.tuple_offset;
					leaf_out_last <= instr.last_tree;
					// empty tree yields zero
					leaf_out      <= '0;
				end
			end
			S_NODE: begin
				// leaf value or threshold, both end up as the result
				if (node_rd.rvalid) begin
					node_q   <= node_in;
					leaf_out <= node_in.node.value;
				end
			end
			S_FEAT: begin
				if (feat_rd.rvalid) begin
					node_addr <= next_addr;
				end
			end
			default: begin
				node_addr <= node_addr;
			end
		endcase
	end

endmodule

// File: hdl/dt_pe.sv
`timescale 1ns/1ps

module dt_pe #(
	parameter int PE_ID = 0
) (
	input  logic                       clk,
	input  logic                       rst_n,

	input  logic [dt_pkg::LINE_W-1:0]  data_line_in,
	input  logic                       data_line_in_valid,
	input  logic                       data_line_in_last,
	input  logic                       data_line_in_ctrl,
	input  logic                       data_line_in_prog,
	input  logic [dt_pkg::PU_BITS-1:0] data_line_in_pu,
	output logic                       data_line_in_ready,

	output logic [dt_pkg::LINE_W-1:0]  data_line_out,
	output logic                       data_line_out_valid,
	output logic                       data_line_out_last,
	output logic                       data_line_out_ctrl,
	output logic                       data_line_out_prog,
	output logic [dt_pkg::PU_BITS-1:0] data_line_out_pu,

	output logic [dt_pkg::FEAT_W-1:0]  leaf_out,
	output logic                       leaf_out_valid,
	output logic                       leaf_out_last
);
	import dt_pkg::*;

	logic                   node_we;
	logic [NODE_ADDR_W-1:0] node_waddr;
	logic [TREE_ID_W-1:0]   num_trees_m1;
	logic [FEAT_ADDR_W-1:0] lines_per_tuple;
	logic [TREE_ID_W:0]     num_trees_loaded;
	logic [NODE_ADDR_W-1:0] tree_offsets [MAX_TREES];
	logic                   pending_full;

	mem_rd_if #(.ADDR_W(NODE_ADDR_W), .DATA_W(LINE_W)) node_rd ();
	mem_rd_if #(.ADDR_W(FEAT_ADDR_W), .DATA_W(LINE_W)) feat_rd ();
	tree_instr_if instr ();

	////////////////////
	// ingress and node storage
	////////////////////

	pe_ingress #(
		.PE_ID (PE_ID)
	) u_ingress (
		.clk                 (clk),
		.rst_n               (rst_n),
		.data_line_in        (data_line_in),
		.data_line_in_valid  (data_line_in_valid),
		.data_line_in_last   (data_line_in_last),
		.data_line_in_ctrl   (data_line_in_ctrl),
		.data_line_in_prog   (data_line_in_prog),
		.data_line_in_pu     (data_line_in_pu),
		.data_line_out       (data_line_out),
		.data_line_out_valid (data_line_out_valid),
		.data_line_out_last  (data_line_out_last),
		.data_line_out_ctrl  (data_line_out_ctrl),
		.data_line_out_prog  (data_line_out_prog),
		.data_line_out_pu    (data_line_out_pu),
		.node_we             (node_we),
		.node_waddr          (node_waddr),
		.num_trees_m1        (num_trees_m1),
		.lines_per_tuple     (lines_per_tuple),
		.num_trees_loaded    (num_trees_loaded),
		.tree_offsets        (tree_offsets)
	);

	// node lines are written as they pass by
	line_ram #(
		.ADDR_W (NODE_ADDR_W)
	) u_node_ram (
		.clk   (clk),
		.rst_n (rst_n),
		.we    (node_we),
		.waddr (node_waddr),
		.wdata (data_line_in),
		.rd    (node_rd.responder)
	);

	feature_buffer #(
		.PE_ID (PE_ID)
	) u_feat_buf (
		.clk                (clk),
		.rst_n              (rst_n),
		.data_line_in       (data_line_in),
		.data_line_in_valid (data_line_in_valid),
		.lines_per_tuple    (lines_per_tuple),
		.pending_full       (pending_full),
		.leaf_out_valid     (leaf_out_valid),
		.leaf_out_last      (leaf_out_last),
		.data_line_in_ready (data_line_in_ready),
		.rd                 (feat_rd.responder)
	);

	////////////////////
	// issue and walk
	////////////////////

	tuple_issue u_issue (
		.clk              (clk),
		.rst_n            (rst_n),
		.tuple_done_in    (data_line_in_valid && data_line_in_last),
		.num_trees_m1     (num_trees_m1),
		.num_trees_loaded (num_trees_loaded),
		.tree_offsets     (tree_offsets),
		.lines_per_tuple  (lines_per_tuple),
		.pending_full     (pending_full),
		.issue            (instr.issuer)
	);

	tree_walker u_walker (
		.clk            (clk),
		.rst_n          (rst_n),
		.instr          (instr.walker),
		.node_rd        (node_rd.requester),
		.feat_rd        (feat_rd.requester),
		.leaf_out       (leaf_out),
		.leaf_out_valid (leaf_out_valid),
		.leaf_out_last  (leaf_out_last)
	);

endmodule

// File: tb/dt_pe_tb.sv
`timescale 1ns/1ps

module dt_pe_tb;
	import dt_pkg::*;

	localparam int PE_ID = 2;
	localparam int NODE_DEPTH = 2**NODE_ADDR_W;
	localparam int FEAT_DEPTH = 2**FEAT_ADDR_W;
	localparam int READY_TIMEOUT = 2000;
	localparam int LEAF_TIMEOUT = 20000;
	localparam int QUIET_CYCLES = 40;

	logic               clk;
	logic               rst_n;
	logic [LINE_W-1:0]  data_line_in;
	logic               data_line_in_valid;
	logic               data_line_in_last;
	logic               data_line_in_ctrl;
	logic               data_line_in_prog;
	logic [PU_BITS-1:0] data_line_in_pu;
	logic               data_line_in_ready;
	logic [LINE_W-1:0]  data_line_out;
	logic               data_line_out_valid;
	logic               data_line_out_last;
	logic               data_line_out_ctrl;
	logic               data_line_out_prog;
	logic [PU_BITS-1:0] data_line_out_pu;
	logic [FEAT_W-1:0]  leaf_out;
	logic               leaf_out_valid;
	logic               leaf_out_last;

	// reference model state
	logic [LINE_W-1:0] model_nodes [NODE_DEPTH];
	logic [LINE_W-1:0] model_feats [FEAT_DEPTH];
	int                tree_start [MAX_TREES];
	int                model_m1;
	int                model_trees;
	int                model_waddr;
	int                model_wptr;
	logic [LINE_W-1:0] tree_buf [$];

	// leaves seen and leaves predicted
	logic [FEAT_W-1:0] got_val [$];
	logic              got_last [$];
	logic [FEAT_W-1:0] exp_val [$];
	logic              exp_last [$];

	logic [31:0]               rng_state;
	logic [LINE_W+PU_BITS+3:0] fwd_prev;
	logic                      fwd_armed;
	logic                      ready_low_seen;

	dt_pe #(
		.PE_ID (PE_ID)
	) u_dut (
		.clk                 (clk),
		.rst_n               (rst_n),
		.data_line_in        (data_line_in),
		.data_line_in_valid  (data_line_in_valid),
		.data_line_in_last   (data_line_in_last),
		.data_line_in_ctrl   (data_line_in_ctrl),
		.data_line_in_prog   (data_line_in_prog),
		.data_line_in_pu     (data_line_in_pu),
		.data_line_in_ready  (data_line_in_ready),
		.data_line_out       (data_line_out),
		.data_line_out_valid (data_line_out_valid),
		.data_line_out_last  (data_line_out_last),
		.data_line_out_ctrl  (data_line_out_ctrl),
		.data_line_out_prog  (data_line_out_prog),
		.data_line_out_pu    (data_line_out_pu),
		.leaf_out            (leaf_out),
		.leaf_out_valid      (leaf_out_valid),
		.leaf_out_last       (leaf_out_last)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	////////////////////
	// helpers
	////////////////////

	task automatic abort_run();
		$display("tests failed");
		$fatal(1);
	endtask

	task automatic check(string name, logic [127:0] got, logic [127:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
			abort_run();
		end
	endtask

	// xorshift32 with shifts 13 17 5
	function automatic logic [31:0] next_random();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	function automatic logic [LINE_W-1:0] node_line(logic [31:0] value, int right_off,
			int feat_idx, logic right_child, logic left_child);
		return {value, 16'(right_off), 4'b0, 8'(feat_idx), right_child, left_child, 2'b00};
	endfunction

	function automatic logic [LINE_W-1:0] cfg_line(int m1, int lpt);
		return {39'b0, 9'(lpt), 11'b0, 5'(m1)};
	endfunction

	// walk one tree of the model by the node rules of the pe
	function automatic logic [FEAT_W-1:0] ref_walk(int root, int toff);
		int                addr;
		logic [LINE_W-1:0] nd;
		logic [LINE_W-1:0] line;
		logic [FEAT_W-1:0] feat;
		logic [7:0]        idx;
		addr = root;
		for (int step = 0; step < NODE_DEPTH; step++) begin
			nd = model_nodes[addr];
			// both flags clear means a leaf
			if (!nd[3] && !nd[2]) begin
				return nd[63:32];
			end
			idx  = nd[11:4];
			line = model_feats[(toff + idx / 2) % FEAT_DEPTH];
			// odd index is the upper half of the line
			feat = idx[0] ? line[63:32] : line[31:0];
			if (feat < nd[63:32]) begin
				if (!nd[2]) begin
					return nd[63:32];
				end
				addr = (addr + 1) % NODE_DEPTH;
			end else begin
				if (!nd[3]) begin
					return nd[63:32];
				end
				addr = (addr + nd[31:16]) % NODE_DEPTH;
			end
		end
		return '0;
	endfunction

	////////////////////
	// monitor
	////////////////////

	// compare the out group with last cycle's inputs and queue the leaves
	always @(negedge clk) begin
		if (fwd_armed) begin
			check("data_line_out group", {data_line_out, data_line_out_valid,
				data_line_out_last, data_line_out_ctrl, data_line_out_prog,
				data_line_out_pu}, fwd_prev);
		end
		fwd_prev = {data_line_in, data_line_in_valid, data_line_in_last,
			data_line_in_ctrl, data_line_in_prog, data_line_in_pu};
		fwd_armed = rst_n;
		if (rst_n && leaf_out_valid === 1'b1) begin
			got_val.push_back(leaf_out);
			got_last.push_back(leaf_out_last);
		end
		if (rst_n && data_line_in_ready !== 1'b1) begin
			ready_low_seen = 1'b1;
		end
	end

	////////////////////
	// drivers
	////////////////////

	task automatic drive_line(logic [LINE_W-1:0] data, logic valid, logic last,
			logic ctrl, logic prog, logic [PU_BITS-1:0] pu);
		@(posedge clk);
		data_line_in       <= data;
		data_line_in_valid <= valid;
		data_line_in_last  <= last;
		data_line_in_ctrl  <= ctrl;
		data_line_in_prog  <= prog;
		data_line_in_pu    <= pu;
	endtask

	task automatic drive_idle();
		drive_line('0, 1'b0, 1'b0, 1'b0, 1'b0, '0);
	endtask

	task automatic apply_reset();
		@(posedge clk);
		rst_n <= 1'b0;
		drive_idle();
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		model_m1    = 0;
		model_trees = 0;
		model_waddr = 0;
		model_wptr  = 0;
		for (int i = 0; i < MAX_TREES; i++) begin
			tree_start[i] = 0;
		end
		got_val.delete();
		got_last.delete();
		exp_val.delete();
		exp_last.delete();
	endtask

	task automatic send_config(int m1, int lpt);
		drive_line(cfg_line(m1, lpt), 1'b0, 1'b0, 1'b1, 1'b0, '0);
		drive_idle();
		model_m1 = m1;
	endtask

	// full tree in preorder with each right child placed past the left subtree
	task automatic build_full_tree(int depth, int num_feats, bit prune);
		int          size;
		int          pos;
		int          sub;
		int          half;
		logic [31:0] r;
		logic        lc;
		logic        rc;
		tree_buf.delete();
		size = (1 << depth) - 1;
		for (int i = 0; i < size; i++) begin
			pos = i;
			sub = size;
			while (pos != 0) begin
				half = (sub - 1) / 2;
				pos  = (pos <= half) ? pos - 1 : pos - 1 - half;
				sub  = half;
			end
			r = next_random();
			if (sub == 1) begin
				tree_buf.push_back(node_line(next_random(), 0, 0, 1'b0, 1'b0));
			end else begin
				// pruning drops a child now and then
				lc = !(prune && r[3:0] == 4'd0);
				rc = !(prune && r[3:0] == 4'd1);
				tree_buf.push_back(node_line(next_random(), (sub + 1) / 2,
					next_random() % num_feats, rc, lc));
			end
		end
	endtask

	// long chain where left steps one node and right skips one, ending in two leaves
	task automatic build_ladder(int len, int num_feats);
		tree_buf.delete();
		for (int i = 0; i < len; i++) begin
			tree_buf.push_back(node_line(next_random(), 2, next_random() % num_feats,
				1'b1, 1'b1));
		end
		tree_buf.push_back(node_line(next_random(), 0, 0, 1'b0, 1'b0));
		tree_buf.push_back(node_line(next_random(), 0, 0, 1'b0, 1'b0));
	endtask

	task automatic program_tree();
		if (model_trees <= model_m1) begin
			tree_start[model_trees] = model_waddr;
			model_trees++;
		end
		for (int i = 0; i < tree_buf.size(); i++) begin
			drive_line(tree_buf[i], 1'b0, i == tree_buf.size() - 1, 1'b0, 1'b1,
				PU_BITS'(PE_ID));
			model_nodes[model_waddr % NODE_DEPTH] = tree_buf[i];
			model_waddr++;
		end
		drive_idle();
	endtask

	// prog lines for the other pes only
	task automatic send_foreign(int n);
		logic [31:0] r;
		for (int i = 0; i < n; i++) begin
			r = next_random();
			drive_line({next_random(), next_random()}, 1'b0, r[0] || i == n - 1, 1'b0,
				1'b1, PU_BITS'(PE_ID + 1 + r[7:4] % (NUM_PUS - 1)));
		end
		drive_idle();
	endtask

	// called in a cycle with valid low, so ready can only rise from here
	task automatic wait_ready();
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (data_line_in_ready !== 1'b1) begin
			if (cycles == READY_TIMEOUT) begin
				$display("timeout: data_line_in_ready stayed low for %0d cycles", cycles);
				abort_run();
			end
			cycles++;
			@(negedge clk);
		end
	endtask

	task automatic expect_tuple(int toff);
		for (int t = 0; t <= model_m1; t++) begin
			if (t >= model_trees) begin
				exp_val.push_back('0);
			end else begin
				exp_val.push_back(ref_walk(tree_start[t], toff));
			end
			exp_last.push_back(t == model_m1);
		end
	endtask

	// only a tuple end raises pending and occupancy stays under its limit here
	task automatic send_tuple(int n);
		logic [LINE_W-1:0] line;
		int                toff;
		toff = model_wptr;
		wait_ready();
		for (int j = 0; j < n; j++) begin
			line = {next_random(), next_random()};
			drive_line(line, 1'b1, j == n - 1, 1'b0, 1'b0, '0);
			model_feats[model_wptr] = line;
			model_wptr = (model_wptr + 1) % FEAT_DEPTH;
			@(negedge clk);
			if (data_line_in_ready !== 1'b1) begin
				$display("feature line %0d was sent while data_line_in_ready was low", j);
				abort_run();
			end
		end
		drive_idle();
		expect_tuple(toff);
	endtask

	task automatic compare_leaves();
		int cycles;
		int n;
		n = exp_val.size();
		cycles = 0;
		while (got_val.size() < n) begin
			if (cycles == LEAF_TIMEOUT) begin
				$display("timeout: only %0d of %0d leaves arrived", got_val.size(), n);
				abort_run();
			end
			cycles++;
			@(posedge clk);
		end
		// quiet window in which no extra leaf may arrive
		repeat (QUIET_CYCLES) @(posedge clk);
		for (int i = 0; i < n; i++) begin
			check("leaf_out", got_val[i], exp_val[i]);
			check("leaf_out_last", got_last[i], exp_last[i]);
		end
		check("leaf count", got_val.size(), n);
	endtask

	////////////////////
	// tests
	////////////////////

	// random traffic that the monitor compares on the out group
	task automatic test_forwarding();
		logic [31:0] r;
		apply_reset();
		for (int i = 0; i < 40; i++) begin
			r = next_random();
			drive_line({next_random(), next_random()}, 1'b0, r[0], r[1], r[2],
				PU_BITS'(PE_ID + 1 + r[7:4] % (NUM_PUS - 1)));
		end
		drive_idle();
		drive_idle();
	endtask

	task automatic test_single_tree();
		apply_reset();
		send_config(0, 4);
		build_full_tree(3, 8, 1'b0);
		program_tree();
		send_tuple(4);
		compare_leaves();
	endtask

	// three trees by five tuples with last on every third leaf
	task automatic test_multi_tree();
		apply_reset();
		send_config(2, 6);
		build_full_tree(3, 12, 1'b1);
		program_tree();
		build_full_tree(4, 12, 1'b1);
		program_tree();
		build_full_tree(2, 12, 1'b0);
		program_tree();
		send_foreign(5);
		for (int t = 0; t < 5; t++) begin
			send_tuple(6);
		end
		compare_leaves();
	endtask

	// four trees configured and two loaded
	task automatic test_empty_trees();
		apply_reset();
		send_config(3, 3);
		build_full_tree(3, 6, 1'b0);
		program_tree();
		build_full_tree(3, 6, 1'b1);
		program_tree();
		for (int t = 0; t < 3; t++) begin
			send_tuple(3);
		end
		compare_leaves();
	endtask

	// long walks outpace the input so pending fills up
	task automatic test_backpressure();
		apply_reset();
		send_config(3, 100);
		for (int i = 0; i < MAX_TREES; i++) begin
			build_ladder(30, 200);
			program_tree();
		end
		ready_low_seen = 1'b0;
		for (int t = 0; t < 20; t++) begin
			send_tuple(100);
		end
		compare_leaves();
		check("data_line_in_ready dropped", ready_low_seen, 1'b1);
	endtask

	task automatic test_other_pe();
		apply_reset();
		send_config(1, 5);
		send_foreign(6);
		build_full_tree(3, 10, 1'b1);
		program_tree();
		send_foreign(9);
		build_full_tree(4, 10, 1'b1);
		program_tree();
		send_foreign(4);
		for (int t = 0; t < 4; t++) begin
			send_tuple(5);
		end
		compare_leaves();
	endtask

	initial begin
		rst_n              = 1'b0;
		data_line_in       = '0;
		data_line_in_valid = 1'b0;
		data_line_in_last  = 1'b0;
		data_line_in_ctrl  = 1'b0;
		data_line_in_prog  = 1'b0;
		data_line_in_pu    = '0;
		rng_state          = 32'h8cb1_f98d;
		fwd_prev           = '0;
		fwd_armed          = 1'b0;
		ready_low_seen     = 1'b0;
		test_forwarding();
		test_single_tree();
		test_multi_tree();
		test_empty_trees();
		test_backpressure();
		test_other_pe();
		$display("all tests passed");
		$finish;
	end

endmodule

// File: dt_pe.f
hdl/dt_pkg.sv
hdl/dt_ifs.sv
hdl/line_ram.sv
hdl/pe_ingress.sv
hdl/feature_buffer.sv
hdl/tuple_issue.sv
hdl/tree_walker.sv
hdl/dt_pe.sv
tb/dt_pe_tb.sv

// File: Bender.yml
package:
  name: dt_pe

sources:
  - hdl/dt_pkg.sv
  - hdl/dt_ifs.sv
  - hdl/line_ram.sv
  - hdl/pe_ingress.sv
  - hdl/feature_buffer.sv
  - hdl/tuple_issue.sv
  - hdl/tree_walker.sv
  - hdl/dt_pe.sv
  - target: test
    files:
      - tb/dt_pe_tb.sv
